/* src/uart_pkg.sv */
// Shared package for the console transmitter hub
// Frame width constant, transmitter and arbiter state enums

package uart_pkg;

    //////////////////////////////////////////////////////////////////////
    // Frame format
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_BITS = 8;    // Payload bits per 8N1 frame

    //////////////////////////////////////////////////////////////////////
    // State encodings
    //////////////////////////////////////////////////////////////////////

    // Serializer phases, one per part of the frame
    typedef enum logic [1:0] {
        TX_IDLE,     // Line high, waiting for is_new
        TX_START,    // Low start bit
        TX_DATA,     // Payload, LSB first
        TX_STOP      // High stop bit
    } tx_state_t;

    // Arbiter sequencer
    typedef enum logic [1:0] {
        ARB_IDLE,    // Looking for a non-empty queue
        ARB_LAUNCH,  // is_new high for one cycle
        ARB_BUSY     // Frame on the line
    } arb_state_t;

endpackage

/* src/tx_fifo.sv */
// Per-channel byte queue, first word fall through
// Circular buffer with occupancy count, full and empty levels

`timescale 1ns/1ps

module tx_fifo
    import uart_pkg::*;
#(
    parameter int FIFO_DEPTH = 4    // Power of two, at least 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr_en,        // Producer write strobe
    input  logic [DATA_BITS-1:0] wr_data,
    input  logic                 pop,          // Remove head at this edge
    output logic [DATA_BITS-1:0] head_data,    // Oldest byte, no read delay
    output logic                 full,
    output logic                 empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [DATA_BITS-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W:0]       count;      // 0 .. FIFO_DEPTH
    logic                 do_wr;
    logic                 do_pop;

    //////////////////////////////////////////////////////////////////////
    // Status and qualified strobes
    //////////////////////////////////////////////////////////////////////

    assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    assign do_wr  = wr_en && !full;    // Dropped when full, even with a pop
    assign do_pop = pop && !empty;

    assign head_data = mem[rd_ptr];    // Fall through

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap naturally on a power-of-two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // Arbiter only grants a queue that showed data
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("tx_fifo: pop while empty");

endmodule

/* src/tx_arbiter.sv */
// Round-robin arbiter between the channel queues and the transmitter
// Rotating pointer, grant search, launch sequencer, idle status

`timescale 1ns/1ps

module tx_arbiter
    import uart_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [NUM_CHANNELS-1:0]           empty,       // Per queue
    input  logic [NUM_CHANNELS*DATA_BITS-1:0] head_data,   // Packed queue heads
    input  logic                              ready,       // Transmitter free
    output logic [NUM_CHANNELS-1:0]           pop,         // One-hot, grant cycle only
    output logic [DATA_BITS-1:0]              tx_data,
    output logic                              is_new,
    output logic                              idle
);

    localparam int CH_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

    arb_state_t      state;
    logic [CH_W-1:0] ptr;          // Highest priority channel
    logic [CH_W-1:0] grant_idx;    // First non-empty from ptr
    logic [CH_W-1:0] next_ptr;
    logic            any_req;
    logic            launch;       // Grant happens at this edge

    //////////////////////////////////////////////////////////////////////
    // Grant search
    //////////////////////////////////////////////////////////////////////

    // Walk upward from the pointer with wrap, keep the first hit
    always_comb begin
        int unsigned cand;
        grant_idx = '0;
        any_req   = 1'b0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            cand = int'(ptr) + i;
            if (cand >= NUM_CHANNELS) begin
                cand = cand - NUM_CHANNELS;
            end
            if (!any_req && !empty[cand]) begin
                any_req   = 1'b1;
                grant_idx = CH_W'(cand);
            end
        end
    end

    assign next_ptr = (grant_idx == CH_W'(NUM_CHANNELS - 1)) ? '0 : grant_idx + 1'b1;
    assign launch   = (state == ARB_IDLE) && ready && any_req;

    always_comb begin
        pop = '0;
        if (launch) begin
            pop[grant_idx] = 1'b1;    // Queue advances at the grant edge
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ARB_IDLE;
            ptr    <= '0;
            is_new <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (launch) begin
                        ptr    <= next_ptr;    // Rotate past the winner
                        is_new <= 1'b1;
                        state  <= ARB_LAUNCH;
                    end
                end
                ARB_LAUNCH: begin
                    is_new <= 1'b0;    // Transmitter took the byte
                    state  <= ARB_BUSY;
                end
                ARB_BUSY: begin
                    if (ready) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Granted byte held here so the queue is free to move on
    always_ff @(posedge clk) begin
        if (launch) begin
            tx_data <= head_data[grant_idx*DATA_BITS +: DATA_BITS];
        end
    end

    assign idle = (&empty) && (state == ARB_IDLE) && ready;

    a_pop_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(pop))
        else $error("tx_arbiter: more than one queue popped");

    // A pop is always the grant cycle, followed by a single launch cycle
    a_pop_grant: assert property (@(posedge clk) disable iff (rst)
        |pop |=> is_new && (pop == '0) ##1 !is_new)
        else $error("tx_arbiter: pop outside the grant cycle");

endmodule

/* src/uart_tx.sv */
// UART transmitter, 8N1, LSB first
// Bit timer, payload shift register and line driver

`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
#(
    parameter int CLK_FREQ  = 100_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [DATA_BITS-1:0] data,      // Byte to send
    input  logic                 is_new,    // One-cycle launch strobe
    output logic                 tx,        // Serial line, idles high
    output logic                 ready      // High when a byte can be taken
);

    localparam int BIT_CYCLES = CLK_FREQ / BAUD_RATE;                  // Clocks per bit
    localparam int TIMER_W    = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;

    tx_state_t            state;
    logic [TIMER_W-1:0]   timer;      // Clocks spent in the current bit
    logic [2:0]           bit_cnt;    // Payload bit index
    logic [DATA_BITS-1:0] shreg;      // Latched byte, shifts right
    logic                 bit_done;   // Last clock of the current bit

    assign bit_done = (timer == TIMER_W'(BIT_CYCLES - 1));

    //////////////////////////////////////////////////////////////////////
    // Frame sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            timer   <= '0;
            bit_cnt <= '0;
            ready   <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    timer   <= '0;
                    bit_cnt <= '0;
                    if (is_new) begin
                        ready <= 1'b0;    // Busy until stop bit ends
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        timer <= '0;
                        state <= TX_DATA;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        timer <= '0;
                        if (bit_cnt == 3'(DATA_BITS - 1)) begin
                            state <= TX_STOP;    // All payload bits out
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        timer <= '0;
                        ready <= 1'b1;    // Next byte may launch
                        state <= TX_IDLE;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Payload register, loaded on launch and shifted at each bit boundary
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && is_new) begin
            shreg <= data;
        end else if (state == TX_DATA && bit_done) begin
            shreg <= shreg >> 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Line driver
    //////////////////////////////////////////////////////////////////////

    // Registered one cycle behind the state, so every bit is BIT_CYCLES long
    always_ff @(posedge clk) begin
        if (rst) begin
            tx <= 1'b1;    // Valid idle level
        end else begin
            case (state)
                TX_START: tx <= 1'b0;
                TX_DATA:  tx <= shreg[0];
                default:  tx <= 1'b1;    // Idle and stop bit
            endcase
        end
    end

    // The arbiter must never launch into a busy transmitter
    a_launch_when_ready: assert property (@(posedge clk) disable iff (rst)
        is_new |-> ready)
        else $error("uart_tx: is_new while ready is low");

endmodule

/* src/uart_tx_hub.sv */
// Shared console transmitter, top level
// Channel queues, round-robin arbiter and one UART transmitter

`timescale 1ns/1ps

module uart_tx_hub
    import uart_pkg::*;
#(
    parameter int NUM_CHANNELS = 4,
    parameter int FIFO_DEPTH   = 4,              // Power of two
    parameter int CLK_FREQ     = 100_000_000,
    parameter int BAUD_RATE    = 115_200
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [NUM_CHANNELS-1:0]           wr_en,     // One strobe per channel
    input  logic [NUM_CHANNELS*DATA_BITS-1:0] wr_data,   // Channel n at bits n*8 up
    output logic [NUM_CHANNELS-1:0]           full,
    output logic                              tx,
    output logic                              idle
);

    //////////////////////////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////////////////////////

    logic [NUM_CHANNELS-1:0]           q_empty;
    logic [NUM_CHANNELS-1:0]           q_pop;
    logic [NUM_CHANNELS*DATA_BITS-1:0] q_head;     // Packed like wr_data

    logic [DATA_BITS-1:0] arb_data;    // Granted byte
    logic                 arb_is_new;
    logic                 tx_ready;

    //////////////////////////////////////////////////////////////////////
    // Channel queues
    //////////////////////////////////////////////////////////////////////

    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_queue
        tx_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .clk       (clk),
            .rst       (rst),
            .wr_en     (wr_en[ch]),
            .wr_data   (wr_data[ch*DATA_BITS +: DATA_BITS]),
            .pop       (q_pop[ch]),
            .head_data (q_head[ch*DATA_BITS +: DATA_BITS]),
            .full      (full[ch]),
            .empty     (q_empty[ch])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Arbitration and serializer
    //////////////////////////////////////////////////////////////////////

    tx_arbiter #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .empty     (q_empty),
        .head_data (q_head),
        .ready     (tx_ready),
        .pop       (q_pop),
        .tx_data   (arb_data),
        .is_new    (arb_is_new),
        .idle      (idle)
    );

    // Single shared line
    uart_tx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_uart_tx (
        .clk    (clk),
        .rst    (rst),
        .data   (arb_data),
        .is_new (arb_is_new),
        .tx     (tx),
        .ready  (tx_ready)
    );

endmodule

/* testbench/uart_line_monitor.sv */
// Serial line decoder for the hub testbench
// Mid-bit sampling of 8N1 frames, byte strobe and framing error strobe

`timescale 1ns/1ps

module uart_line_monitor
    import uart_pkg::*;
#(
    parameter int BIT_CYCLES = 10    // Clocks per bit
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx,          // Line under observation
    output logic [DATA_BITS-1:0] rx_data,     // Last good byte
    output logic                 rx_valid,    // One clock, from a falling edge
    output logic                 frame_err    // One clock, bad start or stop bit
);

    initial begin
        rx_data   = '0;
        rx_valid  = 1'b0;
        frame_err = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // Frame decoder
    //////////////////////////////////////////////////////////////////////

    // Sampling on the falling edge keeps clear of the registered line
    always begin : decode_frame
        logic [DATA_BITS-1:0] shift;
        logic                 bad;
        @(negedge clk);
        rx_valid  = 1'b0;    // Strobes last one clock
        frame_err = 1'b0;
        if (!rst && tx === 1'b0) begin
            bad = 1'b0;
            // Half a clock into the start bit here, move to its middle
            repeat (BIT_CYCLES / 2) @(negedge clk);
            if (tx !== 1'b0) begin
                bad = 1'b1;    // Start bit too short
            end
            for (int i = 0; i < DATA_BITS; i++) begin
                repeat (BIT_CYCLES) @(negedge clk);
                shift[i] = tx;    // LSB first
            end
            repeat (BIT_CYCLES) @(negedge clk);
            if (tx !== 1'b1) begin
                bad = 1'b1;    // Stop bit must be high
            end
            if (bad) begin
                frame_err = 1'b1;
                $display("Monitor at %0t: framing error on the tx line", $time);
            end else begin
                rx_data  = shift;
                rx_valid = 1'b1;
                $display("Monitor at %0t: byte %02h", $time, shift);
            end
        end
    end

endmodule

/* testbench/tb_uart_tx_hub.sv */
// Testbench for the shared UART transmitter hub
// Stimulus table, queue and round-robin model, line checks, timeout

`timescale 1ns/1ps

module tb_uart_tx_hub
    import uart_pkg::*;
();

    localparam int NUM_CH       = 4;
    localparam int FIFO_DEPTH   = 4;
    localparam int CLK_FREQ     = 1_000_000;
    localparam int BAUD_RATE    = 100_000;
    localparam int BIT_CYCLES   = CLK_FREQ / BAUD_RATE;           // 10 clocks per bit
    localparam int FRAME_CYCLES = (DATA_BITS + 2) * BIT_CYCLES;   // Start, payload, stop
    localparam int MAX_ROWS     = 16;
    localparam int SLOTS        = 64;    // Model storage per channel
    localparam int EXP_DROPS    = 1;     // Fifth write of the burst hits a full queue

    logic                        clk = 1'b0;
    logic                        rst;
    logic [NUM_CH-1:0]           wr_en;
    logic [NUM_CH*DATA_BITS-1:0] wr_data;
    logic [NUM_CH-1:0]           full;
    logic                        tx;
    logic                        idle;
    logic [DATA_BITS-1:0]        rx_data;
    logic                        rx_valid;
    logic                        frame_err;

    // Stimulus table
    logic [NUM_CH-1:0]           row_mask  [MAX_ROWS];
    logic [NUM_CH*DATA_BITS-1:0] row_bytes [MAX_ROWS];    // Channel n at bits n*8 up
    logic                        row_rand  [MAX_ROWS];    // Bytes from $random
    logic                        row_wait  [MAX_ROWS];    // Wait for idle afterwards
    int                          n_rows = 0;

    // Reference model, one circular store per channel
    logic [DATA_BITS-1:0] model_mem  [NUM_CH][SLOTS];
    int                   model_head [NUM_CH];
    int                   model_tail [NUM_CH];
    int                   model_ptr;                       // Round-robin pointer
    logic                 exp_valid;                       // A frame is in flight
    logic [DATA_BITS-1:0] exp_byte;
    int                   exp_ch;

    int value_errors = 0;
    int other_errors = 0;
    int accepted     = 0;
    int dropped      = 0;
    int rx_count     = 0;
    int cycle_count  = 0;
    int timeout_limit;
    int seed;

    uart_tx_hub #(
        .NUM_CHANNELS (NUM_CH),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .CLK_FREQ     (CLK_FREQ),
        .BAUD_RATE    (BAUD_RATE)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .full    (full),
        .tx      (tx),
        .idle    (idle)
    );

    uart_line_monitor #(
        .BIT_CYCLES (BIT_CYCLES)
    ) u_monitor (
        .clk       (clk),
        .rst       (rst),
        .tx        (tx),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .frame_err (frame_err)
    );

    always #5 clk = ~clk;    // 10 ns period

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic add_row(input logic [NUM_CH-1:0] mask, input logic [31:0] bytes,
                           input logic rnd, input logic wait_idle);
        row_mask[n_rows]  = mask;
        row_bytes[n_rows] = bytes;
        row_rand[n_rows]  = rnd;
        row_wait[n_rows]  = wait_idle;
        n_rows++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("[ERROR] %0t %s: expected %0h, got %0h", $time, name, exp, got);
        end
    endtask

    // Round-robin rule: first non-empty queue from the pointer, then rotate past it
    function automatic void grant_next();
        int ch;
        exp_valid = 1'b0;
        for (int i = 0; i < NUM_CH; i++) begin
            ch = (model_ptr + i) % NUM_CH;
            if (!exp_valid && model_head[ch] != model_tail[ch]) begin
                exp_valid      = 1'b1;
                exp_ch         = ch;
                exp_byte       = model_mem[ch][model_head[ch]];
                model_head[ch] = model_head[ch] + 1;
                model_ptr      = (ch + 1) % NUM_CH;
            end
        end
    endfunction

    // Writes only land where full was low at drive time
    task automatic drive_row(input int r);
        logic [NUM_CH*DATA_BITS-1:0] bytes;
        bytes = row_rand[r] ? $random(seed) : row_bytes[r];
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (row_mask[r][ch]) begin
                if (!full[ch]) begin
                    model_mem[ch][model_tail[ch]] = bytes[ch*DATA_BITS +: DATA_BITS];
                    model_tail[ch] = model_tail[ch] + 1;
                    accepted++;
                end else begin
                    dropped++;
                end
            end
        end
        wr_en   = row_mask[r];
        wr_data = bytes;
        if (!exp_valid) begin
            grant_next();    // Idle hub grants on the next edge
        end
    endtask

    task automatic wait_for_idle();
        do begin
            @(posedge clk);
            #1;
        end while (!idle);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Line checks and timeout
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst && rx_valid) begin
            rx_count++;
            assert (exp_valid) else begin
                other_errors++;
                $display("Unexpected frame %02h at %0t with no byte pending", rx_data, $time);
            end
            if (exp_valid) begin
                check_value("rx_data", rx_data, exp_byte);
                grant_next();    // Frame ended, next grant
            end
        end
        if (!rst) begin
            assert (!frame_err) else begin
                other_errors++;
                $display("Framing error seen on the tx line at %0t", $time);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout after %0d cycles, the hub never went idle", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed      = 32'h5209_652f;
        rst       = 1'b1;
        wr_en     = '0;
        wr_data   = '0;
        model_ptr = 0;
        exp_valid = 1'b0;
        exp_byte  = '0;
        exp_ch    = 0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            model_head[ch] = 0;
            model_tail[ch] = 0;
        end
        add_row(4'b0001, 32'h0000_00a5, 1'b0, 1'b1);    // Single frame
        add_row(4'b0010, 32'h0000_3c00, 1'b0, 1'b0);    // Write order on ch1
        add_row(4'b0010, 32'h0000_c300, 1'b0, 1'b0);
        add_row(4'b0010, 32'h0000_8100, 1'b0, 1'b1);
        add_row(4'b1111, 32'h8844_2211, 1'b0, 1'b1);    // All channels at once
        add_row(4'b1111, 32'h0, 1'b1, 1'b1);
        add_row(4'b1111, 32'h0, 1'b1, 1'b0);            // Two rounds queued
        add_row(4'b1111, 32'h0, 1'b1, 1'b1);
        add_row(4'b0001, 32'h0000_005a, 1'b0, 1'b0);    // Keeps the line busy
        for (int i = 0; i < 4; i++) begin
            add_row(4'b0100, 32'h0, 1'b1, 1'b0);        // Fills ch2
        end
        add_row(4'b0100, 32'h0, 1'b1, 1'b1);            // Dropped, ch2 full
        timeout_limit = n_rows * (FIFO_DEPTH * 4 * FRAME_CYCLES) + 200;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_value("tx", tx, 1);       // Line rests high
        check_value("idle", idle, 1);
        check_value("full", full, 0);

        for (int r = 0; r < n_rows; r++) begin
            drive_row(r);
            @(posedge clk);
            #1;
            wr_en = '0;
            if (row_wait[r]) begin
                wait_for_idle();
            end
        end

        // Final state and totals
        check_value("idle", idle, 1);
        check_value("full", full, 0);
        check_value("decoded_bytes", rx_count, accepted);
        check_value("dropped_writes", dropped, EXP_DROPS);
        assert (!exp_valid) else begin
            other_errors++;
            $display("A byte from channel %0d never appeared on the line", exp_ch);
        end

        $display("Summary: %0d value errors, %0d other errors, %0d of %0d bytes decoded",
                 value_errors, other_errors, rx_count, accepted);
        if (value_errors + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* uart_tx_hub.f */
src/uart_pkg.sv
src/tx_fifo.sv
src/tx_arbiter.sv
src/uart_tx.sv
src/uart_tx_hub.sv
testbench/uart_line_monitor.sv
testbench/tb_uart_tx_hub.sv
